/* sim.f */
mem_pkg.sv
retire_if.sv
store_align.sv
load_extract.sv
mem_access_stage.sv
retire_pipe.sv
mem_pipe_top.sv
mem_pipe_properties.sv
tb_mem_pipe.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_pipe -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mem_pipe 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* tb_mem_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_pipe;
    import mem_pkg::*;

    localparam int n_ops       = 400;
    localparam int cycle_limit = n_ops * 9 + 400;
    localparam int drain_idle  = 6;

    typedef struct packed {
        logic       we;
        word_t      adr;
        sel_t       sel;
        word_t      dat;
        logic [2:0] funct;
        logic [1:0] ofs;
        reg_addr_t  rd;
    } bus_exp_t;

    typedef struct packed {
        reg_addr_t   rd;
        word_t       data;
        logic [31:0] due;
    } wb_exp_t;

    logic       CLK;
    logic       rst_n;
    logic       issue_valid;
    logic       issue_ready;
    logic [1:0] issue_class;
    logic [2:0] issue_funct;
    word_t      issue_addr;
    word_t      issue_data;
    reg_addr_t  issue_rd;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_dat_o;
    sel_t       wb_sel;
    word_t      wb_dat_i;
    logic       wb_ack;
    logic       rf_valid;
    reg_addr_t  rf_rd;
    word_t      rf_data;

    word_t       mem [64];
    bus_exp_t    bus_q [$];
    wb_exp_t     wb_q [$];
    bus_exp_t    cur_bus;
    logic        in_cycle;
    logic        pending;
    int          ack_delay;
    int unsigned cycle;
    int          idle_count;
    int          n_issued;
    int          n_accepted;
    int          n_alu;
    int          n_load;
    int          n_store;
    int          n_wb;
    int          n_bus;

    mem_pipe_top i_dut (.*);

    initial
    begin
        CLK = 1'b0;
        forever
            #20 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
            fail_now($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic sel_t store_sel_for(input logic [2:0] funct, input logic [1:0] ofs);
        case (funct)
            sk_word: return 4'b1111;
            sk_half: return (ofs == 2'd3) ? 4'b0000 : (4'b0011 << ofs);
            sk_byte: return 4'b0001 << ofs;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic word_t load_result(input logic [2:0] funct, input logic [1:0] ofs,
                                          input word_t raw);
        logic [7:0]  b;
        logic [15:0] h;
        b = raw[8*ofs +: 8];
        case (ofs)
            2'd0:    h = raw[15:0];
            2'd1:    h = raw[23:8];
            2'd2:    h = raw[31:16];
            default: h = 16'h0000;
        endcase
        case (funct)
            lk_byte:  return {{24{b[7]}}, b};
            lk_ubyte: return {24'h000000, b};
            lk_half:  return (ofs == 2'd3) ? 32'h0 : {{16{h[15]}}, h};
            lk_uhalf: return (ofs == 2'd3) ? 32'h0 : {16'h0000, h};
            default:  return raw;
        endcase
    endfunction

    task automatic check_writeback();
        wb_exp_t e;
        if (rf_valid)
        begin
            if (wb_q.size() == 0)
                fail_now("writeback seen with no ALU or load operation outstanding");
            else
            begin
                e = wb_q.pop_front();
                check_value("writeback cycle", e.due, word_t'(cycle));
                check_value("writeback rd", word_t'(e.rd), word_t'(rf_rd));
                check_value("writeback data", e.data, rf_data);
                n_wb++;
            end
        end
        else if (wb_q.size() != 0 && wb_q[0].due == cycle)
            fail_now("expected writeback did not appear");
    endtask

    ////////////////////////////////////////
    // Wishbone slave memory
    ////////////////////////////////////////

    task automatic serve_bus();
        if (wb_ack)
        begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end
        // Junk on the data lines except at ack
        wb_dat_i = $urandom;
        if (wb_cyc && !in_cycle)
        begin
            if (bus_q.size() == 0)
                fail_now("bus cycle started with no memory operation issued");
            else
            begin
                cur_bus   = bus_q.pop_front();
                in_cycle  = 1'b1;
                ack_delay = $urandom % 5;
                n_bus++;
                check_value("bus we", word_t'(cur_bus.we), word_t'(wb_we));
                check_value("bus adr", cur_bus.adr, wb_adr);
                check_value("bus sel", word_t'(cur_bus.sel), word_t'(wb_sel));
                if (cur_bus.we)
                    check_value("bus dat_o", cur_bus.dat, wb_dat_o);
            end
        end
        if (in_cycle)
        begin
            if (ack_delay > 0)
                ack_delay--;
            else
            begin
                wb_ack = 1'b1;
                if (wb_we)
                begin
                    for (int i = 0; i < 4; i++)
                        if (wb_sel[i])
                            mem[wb_adr[7:2]][8*i +: 8] = wb_dat_o[8*i +: 8];
                end
                else
                begin
                    wb_dat_i = mem[wb_adr[7:2]];
                    wb_q.push_back('{cur_bus.rd,
                                     load_result(cur_bus.funct, cur_bus.ofs, wb_dat_i),
                                     cycle + 4});
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Issue side
    ////////////////////////////////////////

    task automatic drive_issue();
        int unsigned f;
        if (!pending)
        begin
            if (n_issued < n_ops && ($urandom % 4) != 0)
            begin
                issue_valid = 1'b1;
                issue_class = 2'($urandom % 3);
                issue_addr  = $urandom;
                issue_data  = $urandom;
                issue_rd    = 5'($urandom);
                f           = $urandom % 5;
                case (issue_class)
                    op_load:  issue_funct = 3'(f >= 3 ? f + 1 : f);
                    op_store: issue_funct = 3'($urandom % 3);
                    default:  issue_funct = 3'($urandom);
                endcase
                pending = 1'b1;
                n_issued++;
            end
            else
                issue_valid = 1'b0;
        end
    endtask

    task automatic record_accept();
        word_t adr;
        adr = {issue_addr[31:2], 2'b00};
        n_accepted++;
        pending = 1'b0;
        case (issue_class)
            op_alu:
            begin
                n_alu++;
                wb_q.push_back('{issue_rd, issue_addr, cycle + 5});
            end
            op_load:
            begin
                n_load++;
                bus_q.push_back('{1'b0, adr, 4'hf, 32'h0, issue_funct,
                                  issue_addr[1:0], issue_rd});
            end
            default:
            begin
                n_store++;
                bus_q.push_back('{1'b1, adr, store_sel_for(issue_funct, issue_addr[1:0]),
                                  issue_data << (8 * issue_addr[1:0]), issue_funct,
                                  issue_addr[1:0], issue_rd});
            end
        endcase
    endtask

    initial
    begin
        void'($urandom(32'h267cbb25));
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_class = 2'd0;
        issue_funct = 3'd0;
        issue_addr  = '0;
        issue_data  = '0;
        issue_rd    = '0;
        wb_dat_i    = '0;
        wb_ack      = 1'b0;
        in_cycle    = 1'b0;
        pending     = 1'b0;
        ack_delay   = 0;
        cycle       = 0;
        idle_count  = 0;
        n_issued    = 0;
        n_accepted  = 0;
        n_alu       = 0;
        n_load      = 0;
        n_store     = 0;
        n_wb        = 0;
        n_bus       = 0;
        for (int i = 0; i < 64; i++)
            mem[i] = $urandom;

        repeat (8) @(negedge CLK);
        rst_n = 1'b1;
        @(negedge CLK);
        check_value("reset wb_cyc", 32'd0, word_t'(wb_cyc));
        check_value("reset wb_stb", 32'd0, word_t'(wb_stb));
        check_value("reset wb_we", 32'd0, word_t'(wb_we));
        check_value("reset rf_valid", 32'd0, word_t'(rf_valid));
        check_value("reset issue_ready", 32'd1, word_t'(issue_ready));

        // Writeback lands at most five cycles after the last acceptance or ack
        while (idle_count < drain_idle && cycle < cycle_limit)
        begin
            @(negedge CLK);
            cycle++;
            check_writeback();
            serve_bus();
            drive_issue();
            #1;
            if (wb_cyc && !wb_ack)
                check_value("issue_ready while bus waits", 32'd0, word_t'(issue_ready));
            if (issue_valid && issue_ready)
                record_accept();
            if (n_accepted == n_ops && !wb_cyc)
                idle_count++;
            else
                idle_count = 0;
        end

        if (cycle >= cycle_limit)
        begin
            $display("run timed out after %0d cycles with %0d of %0d operations accepted",
                     cycle, n_accepted, n_ops);
            $display("TESTBENCH FAILED");
            $fatal(1, "run ended in failure");
        end
        else
        begin
            check_value("writeback total", word_t'(n_alu + n_load), word_t'(n_wb));
            check_value("bus cycle total", word_t'(n_load + n_store), word_t'(n_bus));
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* mem_pipe_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_properties (
    input logic           CLK,
    input logic           rst_n,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input logic           wb_ack,
    input mem_pkg::word_t wb_adr,
    input mem_pkg::word_t wb_dat_o,
    input mem_pkg::sel_t  wb_sel,
    input logic           rf_valid,
    input logic           retire_valid
);

    a_stb_cyc: assert property (@(posedge CLK) disable iff (!rst_n) wb_stb == wb_cyc)
        else $error("wb_stb differs from wb_cyc");

    // Request frozen until the slave acks
    a_req_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_we)
                                 && $stable(wb_sel) && $stable(wb_dat_o)))
        else $error("bus request changed before ack");

    // Three post-access stages between retire and writeback
    a_rf_source: assert property (@(posedge CLK) disable iff (!rst_n)
        rf_valid |-> $past(retire_valid, 3))
        else $error("rf_valid without a retired operation three cycles earlier");

    a_reset_idle: assert property (@(posedge CLK) $rose(rst_n) |-> (!wb_cyc && !rf_valid))
        else $error("bus or writeback active right after reset");

endmodule

bind mem_pipe_top mem_pipe_properties i_props (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_ack       (wb_ack),
    .wb_adr       (wb_adr),
    .wb_dat_o     (wb_dat_o),
    .wb_sel       (wb_sel),
    .rf_valid     (rf_valid),
    .retire_valid (retire_bus.valid)
);

`default_nettype wire

/* mem_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  logic [1:0]         issue_class,
    input  logic [2:0]         issue_funct,
    input  mem_pkg::word_t     issue_addr,
    input  mem_pkg::word_t     issue_data,
    input  mem_pkg::reg_addr_t issue_rd,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output mem_pkg::word_t     wb_adr,
    output mem_pkg::word_t     wb_dat_o,
    output mem_pkg::sel_t      wb_sel,
    input  mem_pkg::word_t     wb_dat_i,
    input  logic               wb_ack,
    output logic               rf_valid,
    output mem_pkg::reg_addr_t rf_rd,
    output mem_pkg::word_t     rf_data
);
    import mem_pkg::*;

    op_class_e  issue_class_t;
    mem_funct_u issue_funct_t;

    assign issue_class_t = op_class_e'(issue_class);
    assign issue_funct_t = mem_funct_u'(issue_funct);

    retire_if retire_bus ();

    mem_access_stage i_access (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_class (issue_class_t),
        .issue_funct (issue_funct_t),
        .issue_addr  (issue_addr),
        .issue_data  (issue_data),
        .issue_rd    (issue_rd),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .retire      (retire_bus.producer)
    );

    retire_pipe i_retire (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .retire   (retire_bus.consumer),
        .rf_valid (rf_valid),
        .rf_rd    (rf_rd),
        .rf_data  (rf_data)
    );

endmodule

`default_nettype wire

/* retire_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_pipe (
    input  logic               CLK,
    input  logic               rst_n,
    retire_if.consumer         retire,
    output logic               rf_valid,
    output mem_pkg::reg_addr_t rf_rd,
    output mem_pkg::word_t     rf_data
);
    import mem_pkg::*;

    // Index 0 is mem2, then mem3, last is wb
    logic       valid_q [n_post_stages];
    op_class_e  class_q [n_post_stages];
    mem_funct_u funct_q [n_post_stages];
    reg_addr_t  rd_q    [n_post_stages];
    logic [1:0] ofs_q   [n_post_stages];
    word_t      data_q  [n_post_stages];
    word_t      load_value;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < n_post_stages; i++)
                valid_q[i] <= 1'b0;
        end
        else
        begin
            valid_q[0] <= retire.valid;
            for (int i = 1; i < n_post_stages; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    // Stages shift every cycle since nothing stalls after the access
    always_ff @(posedge CLK)
    begin
        class_q[0] <= retire.op_class;
        funct_q[0] <= retire.funct;
        rd_q[0]    <= retire.rd;
        ofs_q[0]   <= retire.byte_ofs;
        data_q[0]  <= retire.data;
        for (int i = 1; i < n_post_stages; i++)
        begin
            class_q[i] <= class_q[i-1];
            funct_q[i] <= funct_q[i-1];
            rd_q[i]    <= rd_q[i-1];
            ofs_q[i]   <= ofs_q[i-1];
            data_q[i]  <= data_q[i-1];
        end
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    load_extract i_extract (
        .funct    (funct_q[wb_stage]),
        .byte_ofs (ofs_q[wb_stage]),
        .raw      (data_q[wb_stage]),
        .value    (load_value)
    );

    assign rf_valid = valid_q[wb_stage] && (class_q[wb_stage] != op_store);
    assign rf_rd    = rd_q[wb_stage];
    assign rf_data  = (class_q[wb_stage] == op_load) ? load_value : data_q[wb_stage];

endmodule

`default_nettype wire

/* mem_access_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  mem_pkg::op_class_e  issue_class,
    input  mem_pkg::mem_funct_u issue_funct,
    input  mem_pkg::word_t      issue_addr,
    input  mem_pkg::word_t      issue_data,
    input  mem_pkg::reg_addr_t  issue_rd,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output mem_pkg::word_t      wb_adr,
    output mem_pkg::word_t      wb_dat_o,
    output mem_pkg::sel_t       wb_sel,
    input  mem_pkg::word_t      wb_dat_i,
    input  logic                wb_ack,
    retire_if.producer          retire
);
    import mem_pkg::*;

    logic       busy;
    op_class_e  op_class_q;
    mem_funct_u funct_q;
    word_t      addr_q;
    word_t      data_q;
    reg_addr_t  rd_q;
    logic       accept;
    logic       complete;
    sel_t       store_sel;

    store_align i_align (
        .funct        (funct_q),
        .addr         (addr_q),
        .store_data   (data_q),
        .word_addr    (wb_adr),
        .sel          (store_sel),
        .shifted_data (wb_dat_o)
    );

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // ALU ops finish in one cycle, memory ops wait for ack
    assign complete    = busy && ((op_class_q == op_alu) || wb_ack);
    assign issue_ready = !busy || complete;
    assign accept      = issue_valid && issue_ready;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (accept)
            busy <= 1'b1;
        else if (complete)
            busy <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_class_q <= issue_class;
            funct_q    <= issue_funct;
            addr_q     <= issue_addr;
            data_q     <= issue_data;
            rd_q       <= issue_rd;
        end
    end

    ////////////////////////////////////////
    // Wishbone classic master
    ////////////////////////////////////////

    // Request held from the stage registers until ack
    assign wb_cyc = busy && (op_class_q != op_alu);
    assign wb_stb = wb_cyc;
    assign wb_we  = wb_cyc && (op_class_q == op_store);
    assign wb_sel = (op_class_q == op_store) ? store_sel : {sel_w{1'b1}};

    ////////////////////////////////////////
    // Hand-off to the post-access stages
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
            retire.valid <= 1'b0;
        else
            retire.valid <= complete;
    end

    always_ff @(posedge CLK)
    begin
        if (complete)
        begin
            retire.op_class <= op_class_q;
            retire.funct    <= funct_q;
            retire.rd       <= rd_q;
            retire.byte_ofs <= addr_q[1:0];
            retire.data     <= (op_class_q == op_load) ? wb_dat_i : addr_q;
        end
    end

endmodule

`default_nettype wire

/* load_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  mem_pkg::mem_funct_u funct,
    input  logic [1:0]          byte_ofs,
    input  mem_pkg::word_t      raw,
    output mem_pkg::word_t      value
);
    import mem_pkg::*;

    word_t       lanes;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        half_ok;

    // Bring the addressed byte down to bit 0
    assign lanes     = raw >> {byte_ofs, 3'b000};
    assign byte_lane = lanes[7:0];
    assign half_lane = lanes[15:0];
    assign half_ok   = (byte_ofs != 2'b11);

    always_comb
    begin
        case (funct.load_kind)
            lk_byte:
            begin
                value = {{(xlen-8){byte_lane[7]}}, byte_lane};
            end
            lk_ubyte:
            begin
                value = {{(xlen-8){1'b0}}, byte_lane};
            end
            lk_half:
            begin
                value = half_ok ? {{(xlen-16){half_lane[15]}}, half_lane} : '0;
            end
            lk_uhalf:
            begin
                value = half_ok ? {{(xlen-16){1'b0}}, half_lane} : '0;
            end
            // Words and unknown codes pass through
            default:
            begin
                value = raw;
            end
        endcase
    end

endmodule

`default_nettype wire

/* store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  mem_pkg::mem_funct_u funct,
    input  mem_pkg::word_t      addr,
    input  mem_pkg::word_t      store_data,
    output mem_pkg::word_t      word_addr,
    output mem_pkg::sel_t       sel,
    output mem_pkg::word_t      shifted_data
);
    import mem_pkg::*;

    logic [1:0] ofs;

    assign ofs       = addr[1:0];
    assign word_addr = {addr[xlen-1:2], 2'b00};

    // Eight bits per byte of offset
    assign shifted_data = store_data << {ofs, 3'b000};

    always_comb
    begin
        case (funct.store_kind)
            sk_word:
            begin
                sel = 4'b1111;
            end
            sk_half:
            begin
                case (ofs)
                    2'b00:   sel = 4'b0011;
                    2'b01:   sel = 4'b0110;
                    2'b10:   sel = 4'b1100;
                    // Crosses the word so nothing is written
                    default: sel = 4'b0000;
                endcase
            end
            sk_byte:
            begin
                sel = sel_t'(1) << ofs;
            end
            default:
            begin
                sel = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* retire_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface retire_if;
    import mem_pkg::*;

    logic       valid;
    op_class_e  op_class;
    mem_funct_u funct;
    reg_addr_t  rd;
    logic [1:0] byte_ofs;
    // ALU result, or raw bus word for loads
    word_t      data;

    modport producer (
        output valid,
        output op_class,
        output funct,
        output rd,
        output byte_ofs,
        output data
    );

    modport consumer (
        input valid,
        input op_class,
        input funct,
        input rd,
        input byte_ofs,
        input data
    );

endinterface

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int xlen          = 32;
    localparam int reg_addr_w    = 5;
    localparam int sel_w         = 4;

    // Registers after the retire interface: mem2, mem3, wb
    localparam int n_post_stages = 3;
    localparam int wb_stage      = n_post_stages - 1;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [sel_w-1:0]      sel_t;

    ////////////////////////////////////////
    // Operation encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        op_alu   = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } op_class_e;

    typedef enum logic [2:0] {
        lk_byte  = 3'd0,
        lk_half  = 3'd1,
        lk_word  = 3'd2,
        lk_ubyte = 3'd4,
        lk_uhalf = 3'd5
    } load_kind_e;

    typedef enum logic [2:0] {
        sk_byte = 3'd0,
        sk_half = 3'd1,
        sk_word = 3'd2
    } store_kind_e;

    // Function field read as a load or store kind by op class
    typedef union packed {
        load_kind_e  load_kind;
        store_kind_e store_kind;
    } mem_funct_u;

endpackage

`default_nettype wire
